// File: wdt_top.f
src/wdt_pkg.sv
src/wdt_ctl_if.sv
src/wdt_regs.sv
src/wdt_counter.sv
src/wdt_flag.sv
src/wdt_top.sv
verification/wdt_assert.sv
verification/wdt_tb.sv

// File: Bender.yml
package:
  name: wdt

sources:
  - files:
      - src/wdt_pkg.sv
      - src/wdt_ctl_if.sv
      - src/wdt_regs.sv
      - src/wdt_counter.sv
      - src/wdt_flag.sv
      - src/wdt_top.sv
  - target: test
    files:
      - verification/wdt_assert.sv
      - verification/wdt_tb.sv

// File: verification/wdt_tb.sv
//------------------------------
// Watchdog timer testbench
// Table-driven stimulus on the peripheral bus and strobes
//------------------------------

`timescale 1ns/1ps
`default_nettype none

module wdt_tb import wdt_pkg::*; ();

  //------------------------------
  // Table encoding
  //------------------------------
  localparam logic [2:0] OP_WR     = 3'd0;  // Write WDTCTL then idle
  localparam logic [2:0] OP_RD     = 3'd1;  // Read WDTCTL
  localparam logic [2:0] OP_RDX    = 3'd2;  // Read another address
  localparam logic [2:0] OP_RUN    = 3'd3;  // Configure and clear flag then count
  localparam logic [2:0] OP_RUNCLR = 3'd4;  // OP_RUN with a counter clear every 40 cycles
  localparam logic [2:0] OP_STB    = 3'd5;  // Flag strobe with its code in data[1:0]

  localparam logic [1:0] PAT_LO  = 2'd0;  // smclk_en pattern
  localparam logic [1:0] PAT_HI  = 2'd1;
  localparam logic [1:0] PAT_RND = 2'd2;

  localparam logic [13:0] WDTCTL_WADDR = 14'h0090;

  typedef struct packed {
    logic [2:0]  op;
    logic [15:0] data;      // Password byte and control byte
    logic [15:0] cycles;
    logic [1:0]  pat;
    logic        dbg;
    logic        ie;
    logic [7:0]  rise;      // Enabled ticks to expiry or 0 for none
    logic [15:0] exp_dout;
    logic        chk_ifg;   // Check flag and irq at the end
    logic        exp_ifg;
    logic        exp_irq;
    logic [1:0]  exp_rst;   // Reset pulses for non-run ops
  } test_t;

  logic      mclk;
  logic      puc_rst;
  per_addr_t per_addr;
  per_data_t per_din;
  logic      per_en;
  per_we_t   per_we;
  logic      aclk_en;
  logic      smclk_en;
  logic      dbg_freeze;
  logic      wdtie;
  logic      wdtifg_sw_set;
  logic      wdtifg_sw_clr;
  logic      wdtifg_irq_clr;
  per_data_t per_dout;
  logic      wdtifg;
  logic      wdt_irq;
  logic      wdt_reset;

  test_t       tests[$];
  logic [31:0] rng = 32'h87f4_0a48;
  int          err_cnt = 0;
  int          test_fails = 0;
  int          cur_test = 0;
  int          budget = 0;  // Cycle limit for the timeout

  wdt_top wdt_top_inst (
    .mclk           (mclk),
    .puc_rst        (puc_rst),
    .per_addr       (per_addr),
    .per_din        (per_din),
    .per_en         (per_en),
    .per_we         (per_we),
    .aclk_en        (aclk_en),
    .smclk_en       (smclk_en),
    .dbg_freeze     (dbg_freeze),
    .wdtie          (wdtie),
    .wdtifg_sw_set  (wdtifg_sw_set),
    .wdtifg_sw_clr  (wdtifg_sw_clr),
    .wdtifg_irq_clr (wdtifg_irq_clr),
    .per_dout       (per_dout),
    .wdtifg         (wdtifg),
    .wdt_irq        (wdt_irq),
    .wdt_reset      (wdt_reset)
  );

  initial begin
    mclk = 1'b0;
    forever #2 mclk = ~mclk;  // 4 ns period
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic add_test(input logic [2:0] op, input logic [15:0] data, input int cycles,
                          input logic [1:0] pat, input logic dbg, input logic ie,
                          input logic [7:0] rise, input logic [15:0] exp_dout,
                          input logic chk_ifg, input logic exp_ifg, input logic exp_irq,
                          input logic [1:0] exp_rst);
    tests.push_back({op, data, cycles[15:0], pat, dbg, ie, rise, exp_dout,
                     chk_ifg, exp_ifg, exp_irq, exp_rst});
    budget += cycles;
  endtask

  task automatic check_val(input string sig, input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp) else begin
      $display("FAIL %s: got 0x%h, expected 0x%h (test %0d)", sig, got, exp, cur_test);
      err_cnt++;
    end
  endtask

  task automatic drive_write(input logic [15:0] d);
    per_en <= 1'b1;
    per_we <= 2'b11;
    per_din <= d;
  endtask

  //------------------------------
  // Stimulus table
  //------------------------------
  task automatic build_table();
    logic [7:0] b;
    logic [7:0] pw;
    int k;
    for (k = 0; k < 4; k++) begin
      rng = xorshift32(rng);
      b = rng[7:0];
      add_test(OP_WR, {8'h5A, b}, 3, PAT_LO, 0, 0, 0, 16'h0, 0, 0, 0, 0);
      add_test(OP_RD, 16'h0, 2, PAT_LO, 0, 0, 0, {8'h69, b & 8'h97}, 0, 0, 0, 0);
    end
    rng = xorshift32(rng);
    add_test(OP_RDX, {2'b00, rng[13:1], 1'b1}, 2, PAT_LO, 0, 0, 0, 16'h0, 0, 0, 0, 0);
    // Bad key still lets the data bits land
    rng = xorshift32(rng);
    pw = (rng[15:8] == 8'h5A) ? 8'hA5 : rng[15:8];
    b = rng[7:0];
    add_test(OP_WR, {pw, b}, 3, PAT_LO, 0, 1, 0, 16'h0, 1, 1, b[4], 1);
    add_test(OP_RD, 16'h0, 2, PAT_LO, 0, 0, 0, {8'h69, b & 8'h97}, 0, 0, 0, 0);
    // Interval and watchdog expiry at isx 3
    add_test(OP_RUN, 16'h5A1B, 70, PAT_HI, 0, 1, 64, 16'h0, 0, 0, 0, 0);
    add_test(OP_RUN, 16'h5A1B, 200, PAT_RND, 0, 1, 64, 16'h0, 0, 0, 0, 0);
    add_test(OP_RUN, 16'h5A0B, 70, PAT_HI, 0, 1, 64, 16'h0, 0, 0, 0, 0);
    // No expiry under hold, freeze, ACLK source and periodic clear
    add_test(OP_RUN, 16'h5A9B, 200, PAT_HI, 0, 1, 0, 16'h0, 0, 0, 0, 0);
    add_test(OP_RUN, 16'h5A1B, 200, PAT_HI, 1, 1, 0, 16'h0, 0, 0, 0, 0);
    add_test(OP_RUN, 16'h5A1F, 200, PAT_RND, 0, 1, 0, 16'h0, 0, 0, 0, 0);
    add_test(OP_RUNCLR, 16'h5A1B, 200, PAT_HI, 0, 1, 0, 16'h0, 0, 0, 0, 0);
    // Strobes in interval mode (1 set, 2 clear, 3 ack)
    add_test(OP_WR, 16'h5A10, 3, PAT_LO, 0, 0, 0, 16'h0, 1, 0, 0, 0);
    add_test(OP_STB, 16'd1, 3, PAT_LO, 0, 1, 0, 16'h0, 1, 1, 1, 0);
    add_test(OP_STB, 16'd3, 3, PAT_LO, 0, 1, 0, 16'h0, 1, 0, 0, 0);
    add_test(OP_STB, 16'd1, 3, PAT_LO, 0, 0, 0, 16'h0, 1, 1, 0, 0);
    add_test(OP_STB, 16'd2, 3, PAT_LO, 0, 0, 0, 16'h0, 1, 0, 0, 0);
    // Watchdog mode ignores ack and resets on set
    add_test(OP_WR, 16'h5A00, 3, PAT_LO, 0, 0, 0, 16'h0, 1, 0, 0, 0);
    add_test(OP_STB, 16'd1, 3, PAT_LO, 0, 1, 0, 16'h0, 1, 1, 0, 1);
    add_test(OP_STB, 16'd3, 3, PAT_LO, 0, 1, 0, 16'h0, 1, 1, 0, 0);
    add_test(OP_STB, 16'd2, 3, PAT_LO, 0, 1, 0, 16'h0, 1, 0, 0, 0);
  endtask

  //------------------------------
  // One table entry
  //------------------------------
  task automatic run_test(input test_t t);
    int i;
    int ticks;
    int rst_cnt;
    int fails_before;
    logic en;
    logic mflag;
    logic is_run;
    logic [15:0] exp_rst;
    fails_before = err_cnt;
    ticks = 0;
    rst_cnt = 0;
    exp_rst = t.exp_rst;
    is_run = (t.op == OP_RUN) || (t.op == OP_RUNCLR);
    for (i = 0; i < t.cycles; i++) begin
      en = 1'b0;
      @(posedge mclk);
      per_en <= 1'b0;
      per_we <= 2'b00;
      per_addr <= WDTCTL_WADDR;
      per_din <= 16'h0000;
      smclk_en <= 1'b0;
      wdtifg_sw_set <= 1'b0;
      wdtifg_sw_clr <= 1'b0;
      wdtifg_irq_clr <= 1'b0;
      dbg_freeze <= t.dbg;
      wdtie <= t.ie;
      if (i == 0) begin
        case (t.op)
          OP_RD: per_en <= 1'b1;
          OP_RDX: begin
            per_en <= 1'b1;
            per_addr <= t.data[13:0];
          end
          OP_STB: begin
            wdtifg_sw_set <= (t.data[1:0] == 2'd1);
            wdtifg_sw_clr <= (t.data[1:0] == 2'd2);
            wdtifg_irq_clr <= (t.data[1:0] == 2'd3);
          end
          default: begin
            drive_write(t.data);
            wdtifg_sw_clr <= is_run;  // Runs start from a clear flag
          end
        endcase
      end else if (is_run) begin
        if (t.op == OP_RUNCLR && i % 40 == 0) drive_write(t.data);
        if (t.pat == PAT_HI) en = 1'b1;
        if (t.pat == PAT_RND) begin
          rng = xorshift32(rng);
          en = rng[16];
        end
        smclk_en <= en;
      end
      @(negedge mclk);  // Outputs settled
      if (i == 0 && (t.op == OP_RD || t.op == OP_RDX)) begin
        check_val("per_dout", per_dout, t.exp_dout);
      end
      if (i > 0) begin
        if (wdt_reset) rst_cnt++;
        if (is_run) begin
          mflag = (t.rise != 0) && (ticks >= t.rise);  // Flag follows the tick that expired
          check_val("wdtifg", wdtifg, mflag);
          check_val("wdt_irq", wdt_irq, mflag & t.ie & t.data[4]);
          if (t.rise != 0 && !t.data[4]) exp_rst = ticks / t.rise;
        end
      end
      if (en) ticks++;
    end
    check_val("wdt_reset pulse count", rst_cnt, exp_rst);
    if (t.chk_ifg) begin
      check_val("wdtifg", wdtifg, t.exp_ifg);
      check_val("wdt_irq", wdt_irq, t.exp_irq);
    end
    if (err_cnt != fails_before) test_fails++;
    $display("test %0d op %0d data 0x%h: %s", cur_test, t.op, t.data,
             (err_cnt == fails_before) ? "passed" : "FAILED");
  endtask

  // Timeout from the table length
  initial begin
    wait (budget != 0);
    #((budget + 16 + 50) * 4);
    $display("Timeout: run still busy after %0d cycles", budget + 66);
    $display("Something failed");
    $finish;
  end

  initial begin
    puc_rst = 1'b1;
    per_addr = '0;
    per_din = '0;
    per_en = 1'b0;
    per_we = '0;
    aclk_en = 1'b0;  // ACLK never ticks
    smclk_en = 1'b0;
    dbg_freeze = 1'b0;
    wdtie = 1'b0;
    wdtifg_sw_set = 1'b0;
    wdtifg_sw_clr = 1'b0;
    wdtifg_irq_clr = 1'b0;
    build_table();
    repeat (16) @(posedge mclk);
    puc_rst <= 1'b0;
    foreach (tests[n]) begin
      cur_test = n;
      run_test(tests[n]);
    end
    $display("%0d tests, %0d passed, %0d failed, %0d check errors, %0d assertion failures",
             tests.size(), tests.size() - test_fails, test_fails, err_cnt,
             wdt_top_inst.wdt_assert_inst.fail_cnt);
    if (err_cnt == 0 && wdt_top_inst.wdt_assert_inst.fail_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/wdt_assert.sv
//------------------------------
// Watchdog timer bound checks
// Bus read data, reset pulse width, irq gating
//------------------------------

`timescale 1ns/1ps
`default_nettype none

module wdt_assert import wdt_pkg::*; (
  input logic      mclk,
  input logic      puc_rst,
  input per_addr_t per_addr,
  input logic      per_en,
  input per_we_t   per_we,
  input per_data_t per_dout,
  input logic      wdtifg,
  input logic      wdt_irq,
  input logic      wdt_reset
);

  logic rd_wdtctl;
  int   fail_cnt = 0;  // Assertion failures so far

  // Read of WDTCTL in this cycle
  assign rd_wdtctl = per_en && (per_we == 2'b00) && (per_addr == WDT_BASE_ADDR[14:1]);

  // Read data idles at zero
  dout_idle_zero: assert property (@(posedge mclk) disable iff (puc_rst)
    !rd_wdtctl |-> (per_dout == '0))
    else begin
      $error("per_dout nonzero without a WDTCTL read");
      fail_cnt++;
    end

  // Single-cycle reset request
  reset_one_cycle: assert property (@(posedge mclk) disable iff (puc_rst)
    wdt_reset |=> !wdt_reset)
    else begin
      $error("wdt_reset held for two cycles");
      fail_cnt++;
    end

  irq_needs_flag: assert property (@(posedge mclk) disable iff (puc_rst)
    wdt_irq |-> wdtifg)
    else begin
      $error("wdt_irq high with wdtifg low");
      fail_cnt++;
    end

endmodule

bind wdt_top wdt_assert wdt_assert_inst (.*);

`default_nettype wire

// File: src/wdt_top.sv
//------------------------------
// Watchdog timer top level
// Register block, counter and flag logic on mclk
//------------------------------

`timescale 1ns/1ps
`default_nettype none

module wdt_top import wdt_pkg::*; (
  input  logic      mclk,
  input  logic      puc_rst,         // Async, active high
  // Peripheral bus
  input  per_addr_t per_addr,
  input  per_data_t per_din,
  input  logic      per_en,
  input  per_we_t   per_we,
  // Clock strobes and debug
  input  logic      aclk_en,
  input  logic      smclk_en,
  input  logic      dbg_freeze,
  // Interrupt side
  input  logic      wdtie,
  input  logic      wdtifg_sw_set,
  input  logic      wdtifg_sw_clr,
  input  logic      wdtifg_irq_clr,
  output per_data_t per_dout,
  output logic      wdtifg,
  output logic      wdt_irq,
  output logic      wdt_reset
);

  wdt_ctl_if ctl_if ();  // WDTCTL fields and strobes

  logic wdt_evt;  // Counter expiry to the flag

  //------------------------------
  // Register block
  //------------------------------
  wdt_regs wdt_regs_inst (
    .mclk     (mclk),
    .puc_rst  (puc_rst),
    .per_addr (per_addr),
    .per_din  (per_din),
    .per_en   (per_en),
    .per_we   (per_we),
    .per_dout (per_dout),
    .ctl      (ctl_if.regs)
  );

  // Counter
  wdt_counter wdt_counter_inst (
    .mclk       (mclk),
    .puc_rst    (puc_rst),
    .aclk_en    (aclk_en),
    .smclk_en   (smclk_en),
    .dbg_freeze (dbg_freeze),
    .ctl        (ctl_if.counter),
    .wdt_evt    (wdt_evt)
  );

  // Flag, irq and reset
  wdt_flag wdt_flag_inst (
    .mclk           (mclk),
    .puc_rst        (puc_rst),
    .ctl            (ctl_if.flag),
    .wdt_evt        (wdt_evt),
    .wdtie          (wdtie),
    .wdtifg_sw_set  (wdtifg_sw_set),
    .wdtifg_sw_clr  (wdtifg_sw_clr),
    .wdtifg_irq_clr (wdtifg_irq_clr),
    .wdtifg         (wdtifg),
    .wdt_irq        (wdt_irq),
    .wdt_reset      (wdt_reset)
  );

endmodule

`default_nettype wire

// File: src/wdt_flag.sv
//------------------------------
// Watchdog timer flag and reset
// WDTIFG, interrupt request and reset pulse
//------------------------------

`timescale 1ns/1ps
`default_nettype none

module wdt_flag (
  input  logic    mclk,
  input  logic    puc_rst,
  wdt_ctl_if.flag ctl,
  input  logic    wdt_evt,         // Interval end from the counter
  input  logic    wdtie,           // Interrupt enable
  input  logic    wdtifg_sw_set,
  input  logic    wdtifg_sw_clr,
  input  logic    wdtifg_irq_clr,  // Interrupt acknowledge
  output logic    wdtifg,
  output logic    wdt_irq,
  output logic    wdt_reset        // One-cycle reset request
);

  logic wdtifg_set;
  logic wdtifg_clr;

  // Expiry and bad password both count as events
  assign wdtifg_set = wdt_evt | ctl.pw_error | wdtifg_sw_set;

  // Acknowledge only clears in interval mode
  assign wdtifg_clr = (wdtifg_irq_clr & ctl.tmsel) | wdtifg_sw_clr;

  //------------------------------
  // Interrupt flag
  //------------------------------

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      wdtifg <= 1'b0;
    end else if (wdtifg_set) begin
      wdtifg <= 1'b1;   // Set has priority
    end else if (wdtifg_clr) begin
      wdtifg <= 1'b0;
    end
  end

  assign wdt_irq = ctl.tmsel & wdtifg & wdtie;  // Interval mode only

  //------------------------------
  // Reset pulse
  //------------------------------

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      wdt_reset <= 1'b0;
    end else begin
      // Bad password, or any flag set in watchdog mode
      wdt_reset <= ctl.pw_error | (wdtifg_set & ~ctl.tmsel);
    end
  end

endmodule

`default_nettype wire

// File: src/wdt_counter.sv
//------------------------------
// Watchdog timer counter
// Source select, 16-bit counter and interval taps
//------------------------------

`timescale 1ns/1ps
`default_nettype none

module wdt_counter import wdt_pkg::*; (
  input  logic       mclk,
  input  logic       puc_rst,
  input  logic       aclk_en,     // ACLK tick strobe
  input  logic       smclk_en,    // SMCLK tick strobe
  input  logic       dbg_freeze,  // Debugger halt
  wdt_ctl_if.counter ctl,
  output logic       wdt_evt      // Interval end, combinational
);

  //------------------------------
  // Tick enable
  //------------------------------

  logic clk_src_en;
  logic cnt_incr;

  // ACLK when ssel set, SMCLK otherwise
  assign clk_src_en = ctl.ssel ? aclk_en : smclk_en;

  // Hold and debug freeze stop counting
  assign cnt_incr = clk_src_en & ~ctl.hold & ~dbg_freeze;

  //------------------------------
  // Interval tap
  //------------------------------

  wdt_cnt_t   cnt;
  wdt_cnt_t   cnt_nxt;
  logic [3:0] tap_idx;   // Watched bit position
  logic       tap_bit;

  assign cnt_nxt = cnt + 16'h0001;

  // Tap looked up from the isx code
  assign tap_idx = WDT_TAP_BITS[ctl.isx];
  assign tap_bit = cnt_nxt[tap_idx];

  // Fires on the tick that sets the tapped bit
  assign wdt_evt = tap_bit & cnt_incr;

  //------------------------------
  // Counter
  //------------------------------

  logic cnt_clr_any;

  // Self clear on expiry, software clear, or bad password
  assign cnt_clr_any = wdt_evt | ctl.cnt_clr | ctl.pw_error;

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      cnt <= '0;
    end else if (cnt_clr_any) begin
      cnt <= '0;       // Clear wins over increment
    end else if (cnt_incr) begin
      cnt <= cnt_nxt;
    end
  end

endmodule

`default_nettype wire

// File: src/wdt_regs.sv
//------------------------------
// Watchdog timer register block
// WDTCTL decode, storage, password check and read mux
//------------------------------

`timescale 1ns/1ps
`default_nettype none

module wdt_regs import wdt_pkg::*; (
  input  logic      mclk,
  input  logic      puc_rst,
  input  per_addr_t per_addr,  // Word address
  input  per_data_t per_din,
  input  logic      per_en,
  input  per_we_t   per_we,
  output per_data_t per_dout,  // Combinational, zero when not read
  wdt_ctl_if.regs   ctl
);

  //------------------------------
  // Address decode
  //------------------------------

  logic reg_sel;
  logic reg_wr;
  logic reg_rd;

  // Word address is the byte base without bit 0
  assign reg_sel = per_en & (per_addr == WDT_BASE_ADDR[14:1]);

  assign reg_wr  = reg_sel &  (|per_we);  // Any byte enable makes a write
  assign reg_rd  = reg_sel & ~(|per_we);

  //------------------------------
  // WDTCTL
  //------------------------------

  logic [7:0] wdtctl;  // Masked low byte

  // Data bits are stored even when the password is wrong
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      wdtctl <= 8'h00;  // Watchdog mode, SMCLK, isx 0, running
    end else if (reg_wr) begin
      wdtctl <= per_din[7:0] & WDTCTL_MASK;
    end
  end

  // Field breakout
  assign ctl.hold  = wdtctl[7];
  assign ctl.tmsel = wdtctl[4];
  assign ctl.ssel  = wdtctl[2];
  assign ctl.isx   = wdtctl[1:0];

  //------------------------------
  // Write strobes
  //------------------------------

  // Counter clear in the write cycle
  assign ctl.cnt_clr = reg_wr & per_din[WDT_CNTCL_BIT];

  // Wrong key in the upper byte
  assign ctl.pw_error = reg_wr & (per_din[15:8] != WDT_PASSWORD);

  //------------------------------
  // Read data
  //------------------------------

  // Read key above the stored byte
  always_comb begin
    if (reg_rd) begin
      per_dout = {WDT_READ_KEY, wdtctl};
    end else begin
      per_dout = '0;  // Bus OR friendly
    end
  end

endmodule

`default_nettype wire

// File: src/wdt_ctl_if.sv
//------------------------------
// Watchdog timer control bundle
// WDTCTL fields and strobes from the register block
//------------------------------

`timescale 1ns/1ps
`default_nettype none

interface wdt_ctl_if import wdt_pkg::*; ();

  logic     hold;      // Counter stopped
  logic     tmsel;     // 1 for interval mode, 0 for watchdog mode
  logic     ssel;      // 1 for ACLK, 0 for SMCLK
  wdt_isx_t isx;       // Interval select code
  logic     cnt_clr;   // Software counter clear, one cycle
  logic     pw_error;  // Bad password on a write, one cycle

  // Register block owns every field
  modport regs (output hold, tmsel, ssel, isx, cnt_clr, pw_error);

  // Counter side
  modport counter (input hold, ssel, isx, cnt_clr, pw_error);

  // Flag and reset side
  modport flag (input tmsel, pw_error);

endinterface

`default_nettype wire

// File: src/wdt_pkg.sv
//------------------------------
// Watchdog timer shared definitions
// Bus widths, WDTCTL address, keys and tap table
//------------------------------

`default_nettype none

package wdt_pkg;

  //------------------------------
  // Widths that carry a meaning
  //------------------------------
  typedef logic [13:0] per_addr_t;  // Peripheral word address
  typedef logic [15:0] per_data_t;  // Peripheral data word
  typedef logic [1:0]  per_we_t;    // Byte write enables
  typedef logic [15:0] wdt_cnt_t;   // Watchdog counter value
  typedef logic [1:0]  wdt_isx_t;   // Interval select code

  //------------------------------
  // Register map and keys
  //------------------------------

  // Byte base address, WDTCTL word address is 0x0090
  localparam logic [14:0] WDT_BASE_ADDR = 15'h0120;

  localparam logic [7:0] WDT_PASSWORD = 8'h5A;  // Upper byte on every write
  localparam logic [7:0] WDT_READ_KEY = 8'h69;  // Upper byte on every read

  // Stored low byte bits
  // Bit 7 hold, bit 4 tmsel, bit 2 ssel, bits 1:0 isx
  localparam logic [7:0] WDTCTL_MASK = 8'h97;

  // Write-only counter clear, never stored
  localparam int unsigned WDT_CNTCL_BIT = 3;

  //------------------------------
  // Interval taps
  //------------------------------

  // Counter bit watched per isx code
  // Code 0 -> bit 15 (32768 ticks), 1 -> bit 13 (8192)
  // Code 2 -> bit 9 (512), 3 -> bit 6 (64)
  localparam logic [3:0][3:0] WDT_TAP_BITS = {4'd6, 4'd9, 4'd13, 4'd15};

endpackage

`default_nettype wire
